// ==== sifh_pkg.sv ====
package sifh_pkg;

    // timestamp code width from the tdc, one bin per code
    localparam int bin_bits = 4;
    localparam int bin_num = 1 << bin_bits;

    // pixels per acquisition
    localparam int pixel_num = 4;
    localparam int pixel_bits = (pixel_num > 1) ? $clog2(pixel_num) : 1;

    // events per pixel, acquisitions per frame
    localparam int data_num = 3;
    localparam int acq_num = 2;

    // one bin counter, sized for data_num * acq_num hits
    localparam int count_bits = 4;

    // sequencer counter widths
    localparam int in_bits = (data_num > 1) ? $clog2(data_num) : 1;
    localparam int acq_bits = (acq_num > 1) ? $clog2(acq_num) : 1;

    // one bank holds every pixel/bin pair, pixel in the upper address bits
    localparam int ram_depth = pixel_num * bin_num;
    localparam int ram_addr_bits = pixel_bits + bin_bits;

    // terminal counts, already at the width of the counter they compare with
    localparam logic [in_bits-1:0] in_last = in_bits'(data_num - 1);
    localparam logic [pixel_bits-1:0] pix_last = pixel_bits'(pixel_num - 1);
    localparam logic [acq_bits-1:0] acq_last = acq_bits'(acq_num - 1);
    localparam logic [ram_addr_bits-1:0] addr_last = ram_addr_bits'(ram_depth - 1);

    // sequencer states
    // s_clear lasts exactly one cycle after reset, memory init runs alongside
    typedef enum logic [1:0] {
        s_clear,
        s_count,
        s_swap
    } seq_state_t;

endpackage

// ==== his_inc_if.sv ====
`timescale 1ns/1ps

// increment requests, sequencer -> bin memory
// no handshake, memory takes one request every cycle
interface his_inc_if;

    // one-cycle strobe per event
    logic inc;
    // pixel the event was credited to
    logic [sifh_pkg::pixel_bits-1:0] pixel;
    // bin code of the event
    logic [sifh_pkg::bin_bits-1:0] bin;
    // bank that was active when the event came in
    logic bank;

    modport sender (
        output inc,
        output pixel,
        output bin,
        output bank
    );

    modport receiver (
        input inc,
        input pixel,
        input bin,
        input bank
    );

endinterface

// ==== his_sequencer.sv ====
`timescale 1ns/1ps

module his_sequencer (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          wr_en,
    input  logic [sifh_pkg::bin_bits-1:0] addr,
    his_inc_if.sender                     inc_mp,
    output logic                          his_num,
    output logic                          frame_done
);

    sifh_pkg::seq_state_t state;

    // nested event counters
    logic [sifh_pkg::in_bits-1:0] in_cnt;
    logic [sifh_pkg::pixel_bits-1:0] pix_cnt;
    logic [sifh_pkg::acq_bits-1:0] acq_cnt;

    logic take;
    logic last_in;
    logic last_pix;
    logic last_acq;
    logic frame_end;

    // first request stage
    logic req_valid;
    logic req_bank;
    logic [sifh_pkg::pixel_bits-1:0] req_pixel;
    logic [sifh_pkg::bin_bits-1:0] req_bin;

    // events are ignored only in the init cycle
    assign take = wr_en && (state != sifh_pkg::s_clear);

    assign last_in = (in_cnt == sifh_pkg::in_last);
    assign last_pix = (pix_cnt == sifh_pkg::pix_last);
    assign last_acq = (acq_cnt == sifh_pkg::acq_last);

    // last event of last pixel of last acquisition
    assign frame_end = take && last_in && last_pix && last_acq;

    // s_swap is the one-cycle frame end marker
    assign frame_done = (state == sifh_pkg::s_swap);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sifh_pkg::s_clear;
            in_cnt <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
            his_num <= 1'b0;
        end else begin
            case (state)
                sifh_pkg::s_clear: state <= sifh_pkg::s_count;
                default: state <= frame_end ? sifh_pkg::s_swap : sifh_pkg::s_count;
            endcase
            if (take) begin
                in_cnt <= last_in ? '0 : in_cnt + 1'b1;
                // pixel steps after data_num events
                if (last_in) begin
                    pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
                end
                // acquisition steps after pixel_num pixels
                if (last_in && last_pix) begin
                    acq_cnt <= last_acq ? '0 : acq_cnt + 1'b1;
                end
            end
            // toggles with the edge that enters s_swap
            // the frame-ending event itself still carries the old bank
            if (frame_end) begin
                his_num <= ~his_num;
            end
        end
    end

    // two strobe stages
    // inc lands one cycle after the request is formed
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            req_valid <= 1'b0;
            inc_mp.inc <= 1'b0;
        end else begin
            req_valid <= take;
            inc_mp.inc <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_pixel <= pix_cnt;
            req_bin <= addr;
            req_bank <= his_num;
        end
        if (req_valid) begin
            inc_mp.pixel <= req_pixel;
            inc_mp.bin <= req_bin;
            inc_mp.bank <= req_bank;
        end
    end

    // pipeline must stay empty through the init cycle
    // an event seen during init never comes out of the pipeline either
    a_no_inc_in_clear: assert property (
        @(posedge clk) disable iff (!res)
        (state == sifh_pkg::s_clear) |-> !inc_mp.inc ##2 !inc_mp.inc
    ) else $error("increment issued while memory init is still running");

endmodule

// ==== his_bin_ram.sv ====
`timescale 1ns/1ps

module his_bin_ram (
    input  logic                               clk,
    input  logic                               res,
    his_inc_if.receiver                        inc_mp,
    input  logic                               rd_en,
    input  logic                               rd_bank,
    input  logic [sifh_pkg::ram_addr_bits-1:0] rd_addr,
    output logic [sifh_pkg::count_bits-1:0]    rd_data
);

    // two banks, address is {pixel, bin}
    logic [sifh_pkg::count_bits-1:0] mem [2][sifh_pkg::ram_depth];

    // high for the single cycle after reset
    logic init;

    // read stage
    logic [sifh_pkg::ram_addr_bits-1:0] inc_addr;
    logic fwd;
    logic [sifh_pkg::count_bits-1:0] cur;

    // write stage
    logic wb_valid;
    logic wb_bank;
    logic [sifh_pkg::ram_addr_bits-1:0] wb_addr;
    logic [sifh_pkg::count_bits-1:0] wb_data;

    assign inc_addr = {inc_mp.pixel, inc_mp.bin};

    // same word still sitting in the write stage
    // memory copy is one hit short, take the pending sum
    assign fwd = wb_valid && (wb_bank == inc_mp.bank) && (wb_addr == inc_addr);
    assign cur = fwd ? wb_data : mem[inc_mp.bank][inc_addr];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            init <= 1'b1;
            wb_valid <= 1'b0;
        end else begin
            init <= 1'b0;
            wb_valid <= inc_mp.inc;
        end
    end

    // sum is formed in the read stage, committed one cycle later
    always_ff @(posedge clk) begin
        if (inc_mp.inc) begin
            wb_bank <= inc_mp.bank;
            wb_addr <= inc_addr;
            // no wrap, counts never exceed data_num * acq_num
            wb_data <= cur + 1'b1;
        end
    end

    // single writer for the array
    // increment commit and read-clear never share a bank
    always_ff @(posedge clk) begin
        if (init) begin
            for (int b = 0; b < 2; b++) begin
                for (int a = 0; a < sifh_pkg::ram_depth; a++) begin
                    mem[b][a] <= '0;
                end
            end
        end else begin
            if (wb_valid) begin
                mem[wb_bank][wb_addr] <= wb_data;
            end
            // read-first, old count goes out, word comes back empty
            if (rd_en) begin
                mem[rd_bank][rd_addr] <= '0;
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_bank][rd_addr];
        end
    end

    // readout sits on the finished bank, increments go to the other one
    // a hit on the same bank means a frame finished before its readout
    a_bank_split: assert property (
        @(posedge clk) disable iff (!res)
        (rd_en && inc_mp.inc) |-> (rd_bank != inc_mp.bank)
    ) else $error("readout and increment on the same bank, overrun");

endmodule

// ==== his_readout.sv ====
`timescale 1ns/1ps

module his_readout (
    input  logic                               clk,
    input  logic                               res,
    input  logic                               frame_done,
    input  logic                               his_num,
    input  logic                               rd_req,
    input  logic [sifh_pkg::count_bits-1:0]    rd_data,
    output logic                               rd_en,
    output logic                               rd_bank,
    output logic [sifh_pkg::ram_addr_bits-1:0] rd_addr,
    output logic                               rd_valid,
    output logic [sifh_pkg::pixel_bits-1:0]    rd_pixel,
    output logic [sifh_pkg::bin_bits-1:0]      rd_bin,
    output logic [sifh_pkg::count_bits-1:0]    rd_count,
    output logic                               rd_done,
    output logic                               overrun
);

    // finished bank waiting for the host
    logic pending;
    logic pend_bank;
    // from accept until the last word is out
    logic busy;
    // one spare cycle between accept and first read
    logic start;
    logic accept;
    logic last_addr;

    // requests outside a pending, idle window are dropped
    assign accept = rd_req && pending && !busy;
    assign last_addr = rd_en && (rd_addr == sifh_pkg::addr_last);

    // memory output already lines up with the delayed pixel/bin
    assign rd_count = rd_data;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pending <= 1'b0;
            pend_bank <= 1'b0;
            busy <= 1'b0;
            start <= 1'b0;
            rd_en <= 1'b0;
            rd_bank <= 1'b0;
            rd_addr <= '0;
            rd_valid <= 1'b0;
            rd_done <= 1'b0;
            overrun <= 1'b0;
        end else begin
            // his_num has already flipped so the finished bank is the other one
            if (frame_done) begin
                pending <= 1'b1;
                pend_bank <= ~his_num;
            end else if (accept) begin
                pending <= 1'b0;
            end
            // sticky until reset
            if (frame_done && (pending || busy)) begin
                overrun <= 1'b1;
            end
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
                rd_bank <= pend_bank;
            end else if (rd_done) begin
                busy <= 1'b0;
            end
            // address scan runs pixel-major since pixel is the upper field
            if (start) begin
                rd_en <= 1'b1;
                rd_addr <= '0;
            end else if (rd_en) begin
                rd_addr <= rd_addr + 1'b1;
                if (last_addr) begin
                    rd_en <= 1'b0;
                end
            end
            rd_valid <= rd_en;
            rd_done <= last_addr;
        end
    end

    // word tag with the same latency as the memory read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            {rd_pixel, rd_bin} <= rd_addr;
        end
    end

    // done rides on the last word of the bank
    a_done_with_valid: assert property (
        @(posedge clk) disable iff (!res)
        rd_done |-> rd_valid && ({rd_pixel, rd_bin} == sifh_pkg::addr_last)
    ) else $error("rd_done without the last word on the bus");

endmodule

// ==== sifh_histogram.sv ====
`timescale 1ns/1ps

module sifh_histogram (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            wr_en,
    input  logic [sifh_pkg::bin_bits-1:0]   addr,
    input  logic                            rd_req,
    output logic                            his_num,
    output logic                            frame_done,
    output logic                            rd_valid,
    output logic [sifh_pkg::pixel_bits-1:0] rd_pixel,
    output logic [sifh_pkg::bin_bits-1:0]   rd_bin,
    output logic [sifh_pkg::count_bits-1:0] rd_count,
    output logic                            rd_done,
    output logic                            overrun
);

    // readout <-> memory read port
    logic rd_en;
    logic rd_bank;
    logic [sifh_pkg::ram_addr_bits-1:0] rd_addr;
    logic [sifh_pkg::count_bits-1:0] rd_data;

    // increment path
    his_inc_if u_inc_if ();

    his_sequencer u_his_sequencer (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .addr       (addr),
        .inc_mp     (u_inc_if.sender),
        .his_num    (his_num),
        .frame_done (frame_done)
    );

    his_bin_ram u_his_bin_ram (
        .clk     (clk),
        .res     (res),
        .inc_mp  (u_inc_if.receiver),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    his_readout u_his_readout (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .his_num    (his_num),
        .rd_req     (rd_req),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .rd_done    (rd_done),
        .overrun    (overrun)
    );

endmodule

// ==== tb_sifh_histogram.sv ====
`timescale 1ns/1ps

module tb_sifh_histogram;

    localparam int frame_len = sifh_pkg::data_num * sifh_pkg::pixel_num * sifh_pkg::acq_num;
    localparam int max_gap = 3;
    // five frames with worst-case gaps, three readouts, doubled
    localparam int cycle_limit =
        2 * (5 * frame_len * (1 + max_gap) + 3 * (sifh_pkg::ram_depth + 2));

    logic clk = 1'b0;
    logic res;
    logic wr_en;
    logic [sifh_pkg::bin_bits-1:0] addr;
    logic rd_req;
    logic his_num;
    logic frame_done;
    logic rd_valid;
    logic [sifh_pkg::pixel_bits-1:0] rd_pixel;
    logic [sifh_pkg::bin_bits-1:0] rd_bin;
    logic [sifh_pkg::count_bits-1:0] rd_count;
    logic rd_done;
    logic overrun;

    // reference histogram per bank indexed by pixel * bin_num + bin
    int model [2][sifh_pkg::ram_depth];
    // copy of the bank under readout
    int snap [sifh_pkg::ram_depth];
    int ev_cnt = 0;
    int bank = 0;
    int unread = 0;
    int pend_bank = 0;
    int last_code = 0;
    int word_idx = 0;
    int cycles = 0;
    int errors = 0;
    int err_mark = 0;
    int n_pass = 0;
    int n_fail = 0;
    // marks on the current event or request
    bit end_evt = 0;
    bit ovr_cause = 0;
    bit ovr_exp = 0;
    bit accept_exp = 0;
    bit reading = 0;
    bit idle_chk = 1;

    always #10 clk = ~clk;

    sifh_histogram u_sifh_histogram (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .addr       (addr),
        .rd_req     (rd_req),
        .his_num    (his_num),
        .frame_done (frame_done),
        .rd_valid   (rd_valid),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .rd_done    (rd_done),
        .overrun    (overrun)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // position of the sampled word in the readout stream
    always @(posedge clk) begin
        if (rd_req && accept_exp) begin
            word_idx <= 0;
        end else if (rd_valid) begin
            word_idx <= word_idx + 1;
        end
    end

    // events with random codes and back-to-back runs of one code
    task automatic feed(input int count);
        int gap;
        int code;
        int pix;
        for (int i = 0; i < count; i++) begin
            if ($urandom_range(3) == 0) begin
                code = last_code;
                gap = 0;
            end else begin
                code = $urandom_range(sifh_pkg::bin_num - 1);
                gap = $urandom_range(max_gap);
            end
            repeat (gap) begin
                @(negedge clk);
                wr_en = 1'b0;
            end
            @(negedge clk);
            // data_num events per pixel and pixel_num pixels per acquisition
            pix = (ev_cnt / sifh_pkg::data_num) % sifh_pkg::pixel_num;
            model[bank][pix * sifh_pkg::bin_num + code]++;
            ev_cnt++;
            end_evt = (ev_cnt == frame_len);
            ovr_cause = end_evt && (unread > 0 || reading);
            if (ovr_cause) begin
                ovr_exp = 1'b1;
            end
            wr_en = 1'b1;
            addr = code;
            last_code = code;
            if (end_evt) begin
                ev_cnt = 0;
                unread++;
                pend_bank = bank;
                bank = 1 - bank;
            end
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // request the finished bank
    // the model empties it as the DUT clears on read
    task automatic read_out();
        @(negedge clk);
        accept_exp = (unread > 0) && !reading;
        for (int a = 0; a < sifh_pkg::ram_depth; a++) begin
            snap[a] = model[pend_bank][a];
            model[pend_bank][a] = 0;
        end
        unread--;
        reading = 1'b1;
        rd_req = 1'b1;
        @(negedge clk);
        rd_req = 1'b0;
        accept_exp = 1'b0;
        while (!rd_done) begin
            @(negedge clk);
        end
        // last word still on the bus until the next edge
        @(negedge clk);
        reading = 1'b0;
    endtask

    task automatic end_test(input string name);
        repeat (4) @(negedge clk);
        if (errors == err_mark) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    a_reset_idle: assert property (@(posedge clk) disable iff (!res)
        idle_chk |-> (!his_num && !frame_done && !rd_valid && !rd_done && !overrun))
        else begin
            errors++;
            $display("Mismatch at %0t: outputs not idle after reset", $time);
        end

    a_no_stray_valid: assert property (@(posedge clk) disable iff (!res)
        !reading |-> !rd_valid)
        else begin
            errors++;
            $display("rd_valid came up at %0t without an accepted request", $time);
        end

    a_first_word: assert property (@(posedge clk) disable iff (!res)
        (rd_req && accept_exp) |=> !rd_valid ##1 !rd_valid ##1 rd_valid)
        else begin
            errors++;
            $display("first word at %0t not two cycles after the accepted request", $time);
        end

    a_count: assert property (@(posedge clk) disable iff (!res)
        rd_valid |-> (rd_count == snap[word_idx]))
        else begin
            errors++;
            $display("Mismatch at %0t: word %0d count %0d, expected %0d",
                $time, word_idx, rd_count, snap[word_idx]);
        end

    // pixel-major order with pixel in the upper field
    a_order: assert property (@(posedge clk) disable iff (!res)
        rd_valid |-> ({rd_pixel, rd_bin} == sifh_pkg::ram_addr_bits'(word_idx)))
        else begin
            errors++;
            $display("Mismatch at %0t: word %0d tagged pixel %0d bin %0d",
                $time, word_idx, rd_pixel, rd_bin);
        end

    a_done_last: assert property (@(posedge clk) disable iff (!res)
        rd_valid |-> (rd_done == (word_idx == sifh_pkg::ram_depth - 1)))
        else begin
            errors++;
            $display("Mismatch at %0t: rd_done %0b on word %0d", $time, rd_done, word_idx);
        end

    a_no_extra_word: assert property (@(posedge clk) disable iff (!res)
        rd_done |=> !rd_valid)
        else begin
            errors++;
            $display("a word followed rd_done at %0t", $time);
        end

    a_frame_pulse: assert property (@(posedge clk) disable iff (!res)
        (wr_en && end_evt) |=> frame_done)
        else begin
            errors++;
            $display("Mismatch at %0t: no frame_done after the frame-ending event", $time);
        end

    a_frame_only: assert property (@(posedge clk) disable iff (!res)
        frame_done |-> $past(wr_en && end_evt))
        else begin
            errors++;
            $display("Mismatch at %0t: frame_done without a frame-ending event", $time);
        end

    a_bank_toggle: assert property (@(posedge clk) disable iff (!res)
        frame_done |-> (his_num != $past(his_num)))
        else begin
            errors++;
            $display("Mismatch at %0t: his_num did not toggle with frame_done", $time);
        end

    a_bank_hold: assert property (@(posedge clk) disable iff (!res)
        !frame_done |-> (his_num == $past(his_num)))
        else begin
            errors++;
            $display("Mismatch at %0t: his_num changed outside frame_done", $time);
        end

    a_ovr_rise: assert property (@(posedge clk) disable iff (!res)
        (wr_en && end_evt && ovr_cause) |-> ##2 overrun)
        else begin
            errors++;
            $display("Mismatch at %0t: overrun not set on unread frame", $time);
        end

    a_ovr_sticky: assert property (@(posedge clk) disable iff (!res)
        overrun |=> overrun)
        else begin
            errors++;
            $display("Mismatch at %0t: overrun dropped before reset", $time);
        end

    a_ovr_quiet: assert property (@(posedge clk) disable iff (!res)
        !ovr_exp |-> !overrun)
        else begin
            errors++;
            $display("Mismatch at %0t: overrun set with no unread frame", $time);
        end

    initial begin
        void'($urandom(32'hffe));
        res = 1'b0;
        wr_en = 1'b0;
        addr = '0;
        rd_req = 1'b0;
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < sifh_pkg::ram_depth; a++) begin
                model[b][a] = 0;
            end
        end
        repeat (2) @(negedge clk);
        res = 1'b1;
        repeat (2) @(negedge clk);

        // nothing pending so the request must be dropped
        rd_req = 1'b1;
        @(negedge clk);
        rd_req = 1'b0;
        repeat (6) @(negedge clk);
        idle_chk = 1'b0;
        end_test("reset");

        feed(frame_len);
        end_test("frame_boundaries");

        read_out();
        end_test("histogram_contents");

        // next frame fills the other bank during readout
        // its last event waits so the readout ends first
        feed(frame_len);
        fork
            read_out();
            feed(frame_len - 1);
        join
        feed(1);
        end_test("ping_pong");

        // bank 0 again and only the latest frame may show up
        read_out();
        end_test("clear_on_read");

        feed(frame_len);
        feed(frame_len);
        repeat (8) @(negedge clk);
        end_test("overrun");

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== sifh_histogram.f ====
sifh_pkg.sv
his_inc_if.sv
his_sequencer.sv
his_bin_ram.sv
his_readout.sv
sifh_histogram.sv
tb_sifh_histogram.sv

// ==== Bender.yml ====
package:
  name: sifh_histogram

sources:
  - sifh_pkg.sv
  - his_inc_if.sv
  - his_sequencer.sv
  - his_bin_ram.sv
  - his_readout.sv
  - sifh_histogram.sv
  - target: simulation
    files:
      - tb_sifh_histogram.sv
